//--- logic/wasm_params.svh
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

`define WASM_WIN_BYTES      8
`define WASM_WIN_W          (`WASM_WIN_BYTES * 8)
`define WASM_SHIFT_W        32

// "\0asm" then version 1, byte 0 in the low bits
`define WASM_MAGIC_VERSION  64'h0000_0001_6d73_6100

`define WASM_SEC_TYPE       8'd1
`define WASM_SEC_CODE       8'd10

`define WASM_TYPE_DEPTH     8
`define WASM_TYPE_IDX_W     3

`define WASM_OP_NOP         8'h01
`define WASM_OP_END         8'h0b
`define WASM_OP_DROP        8'h1a
`define WASM_OP_SELECT      8'h1b
`define WASM_OP_LOCAL_GET   8'h20
`define WASM_OP_LOCAL_SET   8'h21
`define WASM_OP_LOCAL_TEE   8'h22
`define WASM_OP_I32_LOAD    8'h28
`define WASM_OP_I32_STORE   8'h36
`define WASM_OP_I32_CONST   8'h41
`define WASM_OP_I32_EQZ     8'h45
`define WASM_OP_I32_EQ      8'h46
`define WASM_OP_I32_NE      8'h47
`define WASM_OP_I32_LT_S    8'h48
`define WASM_OP_I32_LT_U    8'h49
`define WASM_OP_I32_GT_S    8'h4a
`define WASM_OP_I32_GT_U    8'h4b
`define WASM_OP_I32_LE_S    8'h4c
`define WASM_OP_I32_LE_U    8'h4d
`define WASM_OP_I32_GE_S    8'h4e
`define WASM_OP_I32_GE_U    8'h4f
`define WASM_OP_I32_ADD     8'h6a
`define WASM_OP_I32_SUB     8'h6b
`define WASM_OP_I32_AND     8'h71
`define WASM_OP_I32_OR      8'h72
`define WASM_OP_I32_SHL     8'h74
`define WASM_OP_I32_SHR_S   8'h75
`define WASM_OP_I32_SHR_U   8'h76
`define WASM_OP_I32_ROTL    8'h77
`define WASM_OP_I32_ROTR    8'h78

`endif

//--- logic/wasm_pkg.sv
package wasm_pkg;

    typedef enum logic [1:0] {
        module_head    = 2'd0,
        section_head   = 2'd1,
        vector_head    = 2'd2,
        vector_content = 2'd3
    } parse_state_e;

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_and    = 5'd2,
        alu_or     = 5'd3,
        alu_select = 5'd4,
        alu_eqz    = 5'd5,
        alu_eq     = 5'd6,
        alu_lt_u   = 5'd7,
        alu_gt_u   = 5'd8,
        alu_le_u   = 5'd9,
        alu_ge_u   = 5'd10,
        alu_lt_s   = 5'd11,
        alu_gt_s   = 5'd12,
        alu_le_s   = 5'd13,
        alu_ge_s   = 5'd14,
        alu_ne     = 5'd15,
        alu_shl    = 5'd16,
        alu_shr_s  = 5'd17,
        alu_shr_u  = 5'd18,
        alu_rotl   = 5'd19,
        alu_rotr   = 5'd20
    } alu_op_e;

    typedef enum logic [1:0] {
        push_alu       = 2'd0,
        push_mem_const = 2'd2,  // load data or immediate
        push_local     = 2'd3
    } push_src_e;

    typedef struct packed {
        logic [1:0] pop_num;
        logic       push;
        push_src_e  push_src;
    } stack_ctrl_t;

    typedef struct packed {
        logic load_en;
        logic store_en;
        logic local_get;
        logic local_set;
    } mem_ctrl_t;

    typedef struct packed {
        stack_ctrl_t stack;
        alu_op_e     alu_op;
        mem_ctrl_t   mem;
    } exec_ctrl_t;

    typedef struct packed {
        logic [31:0] value;
        logic [2:0]  byte_cnt;
    } leb_t;

endpackage

//--- logic/leb128_decoder.sv
`timescale 1ns/10ps

module leb128_decoder (
    input  logic [39:0]    bytes_in,
    output wasm_pkg::leb_t leb
);

    logic [31:0] value;
    logic [2:0]  cnt;
    logic        done;

    always_comb begin
        value = '0;
        cnt   = 3'd5;
        done  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!done) begin
                value[7*i +: 7] = bytes_in[8*i +: 7];
                if (!bytes_in[8*i+7]) begin   // continuation bit clear
                    done = 1'b1;
                    cnt  = 3'(i + 1);
                end
            end
        end
        // fifth byte only carries the top four bits of a u32
        if (!done) begin
            value[31:28] = bytes_in[35:32];
        end
    end

    assign leb.value    = value;
    assign leb.byte_cnt = cnt;

endmodule

//--- logic/section_parser.sv
`timescale 1ns/10ps
`include "wasm_params.svh"

module section_parser (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`WASM_WIN_W-1:0]      instr,
    input  logic                        instr_vld,
    input  wasm_pkg::leb_t              leb,
    input  logic                        bad_opcode,
    output wasm_pkg::parse_state_e      state,
    output logic [7:0]                  section_id,
    output logic [`WASM_SHIFT_W-1:0]    shift_minus_one,
    output logic                        instr_error,
    input  logic [`WASM_TYPE_IDX_W-1:0] type_idx,
    output logic [7:0]                  param_count,
    output logic [7:0]                  result_count
);

    logic [31:0]                 section_len;
    logic [31:0]                 vec_num;
    logic [31:0]                 vec_cnt;
    logic                        result_half;  // second half of a type entry
    logic [7:0]                  param_tab  [`WASM_TYPE_DEPTH];
    logic [7:0]                  result_tab [`WASM_TYPE_DEPTH];
    logic                        is_type;
    logic                        is_code;
    logic                        last_vec;
    logic                        advance;
    logic                        tab_wr;
    logic [`WASM_TYPE_IDX_W-1:0] tab_idx;

    assign is_type  = (section_id == `WASM_SEC_TYPE);
    assign is_code  = (section_id == `WASM_SEC_CODE);
    assign last_vec = (vec_cnt == vec_num - 32'd1);
    assign advance  = instr_vld && !instr_error;
    assign tab_wr   = (vec_cnt < `WASM_TYPE_DEPTH);  // extra entries are walked, not kept
    assign tab_idx  = vec_cnt[`WASM_TYPE_IDX_W-1:0];

    always_comb begin
        shift_minus_one = '0;
        case (state)
            wasm_pkg::module_head: begin
                shift_minus_one = 32'd7;
            end
            wasm_pkg::section_head: begin
                shift_minus_one = 32'(leb.byte_cnt);  // id byte plus length
            end
            wasm_pkg::vector_head: begin
                if (is_type || is_code) begin
                    shift_minus_one = 32'(leb.byte_cnt) - 32'd1;
                end else begin
                    shift_minus_one = section_len - 32'd1;  // skip whole body
                end
            end
            wasm_pkg::vector_content: begin
                if (is_type) begin
                    if (result_half) begin
                        shift_minus_one = 32'(instr[7:0]);
                    end else begin
                        shift_minus_one = 32'(instr[15:8]) + 32'd1;  // form byte, count, params
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= wasm_pkg::module_head;
            section_id  <= '0;
            vec_cnt     <= '0;
            result_half <= 1'b0;
            instr_error <= 1'b0;
        end else if (advance) begin
            case (state)
                wasm_pkg::module_head: begin
                    if (instr == `WASM_MAGIC_VERSION) begin
                        state <= wasm_pkg::section_head;
                    end else begin
                        instr_error <= 1'b1;
                    end
                end
                wasm_pkg::section_head: begin
                    section_id <= instr[7:0];
                    state      <= wasm_pkg::vector_head;
                end
                wasm_pkg::vector_head: begin
                    vec_cnt     <= '0;
                    result_half <= 1'b0;
                    if ((is_type || is_code) && leb.value != 32'd0) begin
                        state <= wasm_pkg::vector_content;
                    end else begin
                        state <= wasm_pkg::section_head;
                    end
                end
                wasm_pkg::vector_content: begin
                    if (is_code) begin
                        if (bad_opcode) begin
                            instr_error <= 1'b1;
                        end else if (instr[7:0] == `WASM_OP_END) begin
                            vec_cnt <= vec_cnt + 32'd1;
                            if (last_vec) begin
                                state <= wasm_pkg::section_head;
                            end
                        end
                    end else if (is_type) begin
                        result_half <= !result_half;
                        if (result_half) begin
                            vec_cnt <= vec_cnt + 32'd1;
                            if (last_vec) begin
                                state <= wasm_pkg::section_head;
                            end
                        end
                    end else begin
                        state <= wasm_pkg::section_head;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (state == wasm_pkg::section_head) begin
                section_len <= leb.value;
            end
            if (state == wasm_pkg::vector_head) begin
                vec_num <= leb.value;
            end
            if (state == wasm_pkg::vector_content && is_type && tab_wr) begin
                if (result_half) begin
                    result_tab[tab_idx] <= instr[7:0];
                end else begin
                    param_tab[tab_idx] <= instr[15:8];
                end
            end
        end
    end

    assign param_count  = param_tab[type_idx];
    assign result_count = result_tab[type_idx];

endmodule

//--- logic/opcode_decoder.sv
`timescale 1ns/10ps
`include "wasm_params.svh"

module opcode_decoder (
    input  logic [7:0]                 opcode,
    input  wasm_pkg::leb_t             leb,
    input  logic                       active,
    output wasm_pkg::exec_ctrl_t       exec,
    output logic [`WASM_SHIFT_W-1:0]   code_shift,
    output logic                       bad_opcode
);

    logic [`WASM_SHIFT_W-1:0] imm_shift;  // opcode plus one leb immediate

    assign imm_shift = `WASM_SHIFT_W'(leb.byte_cnt);

    // pops operands, pushes the ALU result
    function automatic wasm_pkg::exec_ctrl_t alu_ctrl(
        input logic [1:0]        pops,
        input wasm_pkg::alu_op_e op
    );
        wasm_pkg::exec_ctrl_t c;
        c                = '0;
        c.stack.pop_num  = pops;
        c.stack.push     = 1'b1;
        c.stack.push_src = wasm_pkg::push_alu;
        c.alu_op         = op;
        return c;
    endfunction

    always_comb begin
        exec       = '0;
        code_shift = '0;
        bad_opcode = 1'b0;
        if (active) begin
            case (opcode)
                `WASM_OP_NOP, `WASM_OP_END: ;
                `WASM_OP_DROP: begin
                    exec.stack.pop_num = 2'd1;
                end
                `WASM_OP_SELECT:  exec = alu_ctrl(2'd3, wasm_pkg::alu_select);
                `WASM_OP_I32_EQZ: exec = alu_ctrl(2'd1, wasm_pkg::alu_eqz);
                `WASM_OP_I32_EQ:  exec = alu_ctrl(2'd2, wasm_pkg::alu_eq);
                `WASM_OP_I32_NE:  exec = alu_ctrl(2'd2, wasm_pkg::alu_ne);
                `WASM_OP_I32_LT_S: exec = alu_ctrl(2'd2, wasm_pkg::alu_lt_s);
                `WASM_OP_I32_LT_U: exec = alu_ctrl(2'd2, wasm_pkg::alu_lt_u);
                `WASM_OP_I32_GT_S: exec = alu_ctrl(2'd2, wasm_pkg::alu_gt_s);
                `WASM_OP_I32_GT_U: exec = alu_ctrl(2'd2, wasm_pkg::alu_gt_u);
                `WASM_OP_I32_LE_S: exec = alu_ctrl(2'd2, wasm_pkg::alu_le_s);
                `WASM_OP_I32_LE_U: exec = alu_ctrl(2'd2, wasm_pkg::alu_le_u);
                `WASM_OP_I32_GE_S: exec = alu_ctrl(2'd2, wasm_pkg::alu_ge_s);
                `WASM_OP_I32_GE_U: exec = alu_ctrl(2'd2, wasm_pkg::alu_ge_u);
                `WASM_OP_I32_ADD:  exec = alu_ctrl(2'd2, wasm_pkg::alu_add);
                `WASM_OP_I32_SUB:  exec = alu_ctrl(2'd2, wasm_pkg::alu_sub);
                `WASM_OP_I32_AND:  exec = alu_ctrl(2'd2, wasm_pkg::alu_and);
                `WASM_OP_I32_OR:   exec = alu_ctrl(2'd2, wasm_pkg::alu_or);
                `WASM_OP_I32_SHL:  exec = alu_ctrl(2'd2, wasm_pkg::alu_shl);
                `WASM_OP_I32_SHR_S: exec = alu_ctrl(2'd2, wasm_pkg::alu_shr_s);
                `WASM_OP_I32_SHR_U: exec = alu_ctrl(2'd2, wasm_pkg::alu_shr_u);
                `WASM_OP_I32_ROTL: exec = alu_ctrl(2'd2, wasm_pkg::alu_rotl);
                `WASM_OP_I32_ROTR: exec = alu_ctrl(2'd2, wasm_pkg::alu_rotr);
                `WASM_OP_I32_CONST: begin
                    exec.stack.push     = 1'b1;
                    exec.stack.push_src = wasm_pkg::push_mem_const;
                    code_shift          = imm_shift;
                end
                `WASM_OP_LOCAL_GET: begin
                    exec.stack.push     = 1'b1;
                    exec.stack.push_src = wasm_pkg::push_local;
                    exec.mem.local_get  = 1'b1;
                    code_shift          = imm_shift;
                end
                `WASM_OP_LOCAL_SET: begin
                    exec.stack.pop_num = 2'd1;
                    exec.mem.local_set = 1'b1;
                    code_shift         = imm_shift;
                end
                `WASM_OP_LOCAL_TEE: begin
                    exec.mem.local_set = 1'b1;  // value stays on the stack
                    code_shift         = imm_shift;
                end
                `WASM_OP_I32_LOAD: begin
                    exec.stack.pop_num  = 2'd1;
                    exec.stack.push     = 1'b1;
                    exec.stack.push_src = wasm_pkg::push_mem_const;
                    exec.mem.load_en    = 1'b1;
                    code_shift          = imm_shift + 32'd1;  // align byte plus offset
                end
                `WASM_OP_I32_STORE: begin
                    exec.stack.pop_num = 2'd2;
                    exec.mem.store_en  = 1'b1;
                    code_shift         = imm_shift + 32'd1;
                end
                default: begin
                    bad_opcode = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- logic/wasm_ctrl_unit.sv
`timescale 1ns/10ps
`include "wasm_params.svh"

module wasm_ctrl_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`WASM_WIN_W-1:0]      instr,
    input  logic                        instr_vld,
    input  logic [`WASM_TYPE_IDX_W-1:0] type_idx,
    output logic [`WASM_SHIFT_W-1:0]    shift_minus_one,
    output wasm_pkg::exec_ctrl_t        exec,
    output logic [31:0]                 constant,
    output logic                        instr_error,
    output logic [7:0]                  param_count,
    output logic [7:0]                  result_count
);

    wasm_pkg::parse_state_e   state;
    wasm_pkg::leb_t           leb;
    logic [7:0]               section_id;
    logic [39:0]              leb_in;
    logic                     in_code;
    logic                     active;
    logic                     bad_opcode;
    logic [`WASM_SHIFT_W-1:0] parse_shift;
    logic [`WASM_SHIFT_W-1:0] code_shift;

    // vector count starts at byte 0, everything else follows an id or opcode
    assign leb_in = (state == wasm_pkg::vector_head) ? instr[39:0] : instr[47:8];

    assign in_code = (state == wasm_pkg::vector_content) && (section_id == `WASM_SEC_CODE);
    assign active  = in_code && instr_vld && !instr_error;

    assign shift_minus_one = in_code ? code_shift : parse_shift;
    assign constant        = leb.value;

    leb128_decoder u_leb (
        .bytes_in (leb_in),
        .leb      (leb)
    );

    section_parser u_parser (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr           (instr),
        .instr_vld       (instr_vld),
        .leb             (leb),
        .bad_opcode      (bad_opcode),
        .state           (state),
        .section_id      (section_id),
        .shift_minus_one (parse_shift),
        .instr_error     (instr_error),
        .type_idx        (type_idx),
        .param_count     (param_count),
        .result_count    (result_count)
    );

    opcode_decoder u_opdec (
        .opcode     (instr[7:0]),
        .leb        (leb),
        .active     (active),
        .exec       (exec),
        .code_shift (code_shift),
        .bad_opcode (bad_opcode)
    );

endmodule

//--- test/wasm_ctrl_checker.sv
`timescale 1ns/10ps

module wasm_ctrl_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 instr_vld,
    input wasm_pkg::exec_ctrl_t exec,
    input logic                 instr_error
);

    // nothing issued without a valid window
    idle_no_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_vld |-> (exec.mem == '0 && !exec.stack.push))
        else $error("strobe or push active while instr_vld is low");

    error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        !$fell(instr_error))
        else $error("instr_error cleared without a reset");

    load_store_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(exec.mem.load_en && exec.mem.store_en))
        else $error("load_en and store_en high together");

endmodule

bind wasm_ctrl_unit wasm_ctrl_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_vld   (instr_vld),
    .exec        (exec),
    .instr_error (instr_error)
);

//--- test/wasm_ctrl_tb.sv
`timescale 1ns/10ps
`include "wasm_params.svh"

module wasm_ctrl_tb;

    typedef struct packed {
        logic [63:0]          window;
        logic                 vld;
        logic [31:0]          shift;
        wasm_pkg::exec_ctrl_t exec;
        logic                 chk_const;
        logic [31:0]          constant;
        logic                 err;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic [63:0]          instr;
    logic                 instr_vld;
    logic [2:0]           type_idx;
    logic [31:0]          shift_minus_one;
    wasm_pkg::exec_ctrl_t exec;
    logic [31:0]          constant;
    logic                 instr_error;
    logic [7:0]           param_count;
    logic [7:0]           result_count;

    row_t        rows[$];
    logic [7:0]  wb[$];  // bytes of the next window, byte 0 first
    logic [7:0]  type_np[$];
    logic [7:0]  type_nr[$];
    logic [31:0] lcg_state;
    int          errors;
    int          tests_run;
    int          tests_failed;

    // two-operand ops and the ALU op each one selects
    logic [7:0] bin_op [19] = '{`WASM_OP_I32_EQ, `WASM_OP_I32_NE, `WASM_OP_I32_LT_S,
        `WASM_OP_I32_LT_U, `WASM_OP_I32_GT_S, `WASM_OP_I32_GT_U, `WASM_OP_I32_LE_S,
        `WASM_OP_I32_LE_U, `WASM_OP_I32_GE_S, `WASM_OP_I32_GE_U, `WASM_OP_I32_ADD,
        `WASM_OP_I32_SUB, `WASM_OP_I32_AND, `WASM_OP_I32_OR, `WASM_OP_I32_SHL,
        `WASM_OP_I32_SHR_S, `WASM_OP_I32_SHR_U, `WASM_OP_I32_ROTL, `WASM_OP_I32_ROTR};
    wasm_pkg::alu_op_e bin_alu [19] = '{wasm_pkg::alu_eq, wasm_pkg::alu_ne,
        wasm_pkg::alu_lt_s, wasm_pkg::alu_lt_u, wasm_pkg::alu_gt_s, wasm_pkg::alu_gt_u,
        wasm_pkg::alu_le_s, wasm_pkg::alu_le_u, wasm_pkg::alu_ge_s, wasm_pkg::alu_ge_u,
        wasm_pkg::alu_add, wasm_pkg::alu_sub, wasm_pkg::alu_and, wasm_pkg::alu_or,
        wasm_pkg::alu_shl, wasm_pkg::alu_shr_s, wasm_pkg::alu_shr_u, wasm_pkg::alu_rotl,
        wasm_pkg::alu_rotr};

    wasm_ctrl_unit UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr           (instr),
        .instr_vld       (instr_vld),
        .type_idx        (type_idx),
        .shift_minus_one (shift_minus_one),
        .exec            (exec),
        .constant        (constant),
        .instr_error     (instr_error),
        .param_count     (param_count),
        .result_count    (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // unsigned LEB128, returns the byte count
    function automatic int put_leb(input logic [31:0] v);
        logic [31:0] rest;
        int          n;
        rest = v;
        n    = 1;
        while (rest >= 32'h80) begin
            wb.push_back({1'b1, rest[6:0]});
            rest = rest >> 7;
            n++;
        end
        wb.push_back({1'b0, rest[6:0]});
        return n;
    endfunction

    function automatic logic [63:0] take_window();
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < wb.size() && i < 8; i++) begin
            w[8*i +: 8] = wb[i];
        end
        wb.delete();
        return w;
    endfunction

    function automatic wasm_pkg::exec_ctrl_t mk_exec(input logic [1:0] pops, input logic push,
        input wasm_pkg::push_src_e src, input wasm_pkg::alu_op_e alu,
        input logic ld, input logic st, input logic lg, input logic ls);
        wasm_pkg::exec_ctrl_t e;
        e.stack.pop_num  = pops;
        e.stack.push     = push;
        e.stack.push_src = src;
        e.alu_op         = alu;
        e.mem.load_en    = ld;
        e.mem.store_en   = st;
        e.mem.local_get  = lg;
        e.mem.local_set  = ls;
        return e;
    endfunction

    function automatic void add_row(input logic [63:0] w, input logic vld,
        input logic [31:0] shift, input wasm_pkg::exec_ctrl_t e, input logic chk_const,
        input logic [31:0] c, input logic err);
        rows.push_back('{w, vld, shift, e, chk_const, c, err});
    endfunction

    function automatic void add_header();
        add_row(`WASM_MAGIC_VERSION, 1'b1, 32'd7, '0, 1'b0, 32'd0, 1'b0);
    endfunction

    // section id, length, then a one-byte vector count
    function automatic void add_code_open(input logic [7:0] n);
        int cnt;
        wb.push_back(`WASM_SEC_CODE);
        cnt = put_leb(32'd40);
        add_row(take_window(), 1'b1, cnt, '0, 1'b0, 32'd0, 1'b0);
        wb.push_back(n);
        add_row(take_window(), 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b0);
    endfunction

    function automatic void add_type(input int np, input int nr);
        wb.push_back(8'h60);
        wb.push_back(8'(np));
        for (int i = 0; i < np; i++) wb.push_back(8'h7f);
        add_row(take_window(), 1'b1, np + 1, '0, 1'b0, 32'd0, 1'b0);
        wb.push_back(8'(nr));
        for (int i = 0; i < nr; i++) wb.push_back(8'h7e);
        add_row(take_window(), 1'b1, nr, '0, 1'b0, 32'd0, 1'b0);
        type_np.push_back(8'(np));
        type_nr.push_back(8'(nr));
    endfunction

    task automatic do_reset();
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        instr     = '0;
        instr_vld = 1'b0;
        rows.delete();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic apply_rows();
        row_t r;
        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            #1;
            instr     = r.window;
            instr_vld = r.vld;
            #2;  // outputs settled, next edge still ahead
            if (shift_minus_one != r.shift) begin
                $display("ERR t=%0t shift_minus_one exp=%0d got=%0d",
                         $time, r.shift, shift_minus_one);
                errors++;
            end
            if (exec != r.exec) begin
                $display("ERR t=%0t exec exp=%h got=%h", $time, r.exec, exec);
                errors++;
            end
            if (r.chk_const && constant != r.constant) begin
                $display("ERR t=%0t constant exp=%h got=%h", $time, r.constant, constant);
                errors++;
            end
            if (instr_error != r.err) begin
                $display("ERR t=%0t instr_error exp=%b got=%b", $time, r.err, instr_error);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        instr_vld = 1'b0;
        rows.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        int          n;
        int          consumed;
        int          errs0;
        logic        done;
        logic [31:0] v;
        logic [31:0] sh;
        rst_n        = 1'b0;
        instr        = '0;
        instr_vld    = 1'b0;
        type_idx     = '0;
        lcg_state    = 32'heb00;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        errs0 = errors;
        do_reset();
        add_row(`WASM_MAGIC_VERSION ^ 64'h100, 1'b1, 32'd7, '0, 1'b0, 32'd0, 1'b0);
        for (int i = 0; i < 3; i++) add_header_err();
        apply_rows();
        finish_test("bad header", errs0);

        errs0 = errors;
        do_reset();
        add_header();
        wb.push_back(8'h00);  // custom section
        n = put_leb(32'd300);
        add_row(take_window(), 1'b1, n, '0, 1'b0, 32'd0, 1'b0);
        add_row(64'h0b0b_0b0b_0b0b_0b05, 1'b1, 32'd299, '0, 1'b0, 32'd0, 1'b0);
        wb.push_back(8'h03);
        n = put_leb(32'd20000);
        add_row(take_window(), 1'b1, n, '0, 1'b0, 32'd0, 1'b0);
        apply_rows();
        finish_test("section skip", errs0);

        errs0 = errors;
        do_reset();
        add_header();
        wb.push_back(`WASM_SEC_TYPE);
        n = put_leb(32'd14);
        add_row(take_window(), 1'b1, n, '0, 1'b0, 32'd0, 1'b0);
        add_row(64'h03, 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        add_type(2, 1);
        add_type(0, 1);
        add_type(3, 0);
        add_row(64'h0403, 1'b1, 32'd1, '0, 1'b0, 32'd0, 1'b0);
        apply_rows();
        for (int i = 0; i < type_np.size(); i++) begin
            @(posedge clk);
            #1;
            type_idx = 3'(i);
            #2;
            if (param_count != type_np[i]) begin
                $display("ERR t=%0t param_count exp=%0d got=%0d", $time, type_np[i], param_count);
                errors++;
            end
            if (result_count != type_nr[i]) begin
                $display("ERR t=%0t result_count exp=%0d got=%0d",
                         $time, type_nr[i], result_count);
                errors++;
            end
        end
        finish_test("type section", errs0);

        errs0 = errors;
        do_reset();
        add_header();
        add_code_open(8'd1);
        add_row(64'(`WASM_OP_NOP), 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_DROP), 1'b1, 32'd0, mk_exec(2'd1, 1'b0, wasm_pkg::push_alu,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_SELECT), 1'b1, 32'd0, mk_exec(2'd3, 1'b1, wasm_pkg::push_alu,
                wasm_pkg::alu_select, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_I32_EQZ), 1'b1, 32'd0, mk_exec(2'd1, 1'b1, wasm_pkg::push_alu,
                wasm_pkg::alu_eqz, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        for (int i = 0; i < 19; i++) begin
            add_row(64'(bin_op[i]), 1'b1, 32'd0, mk_exec(2'd2, 1'b1, wasm_pkg::push_alu,
                    bin_alu[i], 1'b0, 1'b0, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        end
        wb.push_back(`WASM_OP_LOCAL_GET);
        n = put_leb(32'd200);
        add_row(take_window(), 1'b1, n, mk_exec(2'd0, 1'b1, wasm_pkg::push_local,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b1, 1'b0), 1'b0, 32'd0, 1'b0);
        wb.push_back(`WASM_OP_LOCAL_SET);
        n = put_leb(32'd3);
        add_row(take_window(), 1'b1, n, mk_exec(2'd1, 1'b0, wasm_pkg::push_alu,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0, 32'd0, 1'b0);
        wb.push_back(`WASM_OP_LOCAL_TEE);
        n = put_leb(32'd130);
        add_row(take_window(), 1'b1, n, mk_exec(2'd0, 1'b0, wasm_pkg::push_alu,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0, 32'd0, 1'b0);
        wb.push_back(`WASM_OP_I32_LOAD);
        n = put_leb(32'd2);  // align, then one offset byte
        wb.push_back(8'h10);
        add_row(take_window(), 1'b1, n + 1, mk_exec(2'd1, 1'b1, wasm_pkg::push_mem_const,
                wasm_pkg::alu_add, 1'b1, 1'b0, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        wb.push_back(`WASM_OP_I32_STORE);
        n = put_leb(32'd2);
        wb.push_back(8'h04);
        add_row(take_window(), 1'b1, n + 1, mk_exec(2'd2, 1'b0, wasm_pkg::push_alu,
                wasm_pkg::alu_add, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        for (int k = 0; k < 6; k++) begin
            v  = lcg_next();
            sh = lcg_next() % 32'd29;  // spread the immediate over 1..5 bytes
            v  = v >> sh;
            wb.push_back(`WASM_OP_I32_CONST);
            n = put_leb(v);
            add_row(take_window(), 1'b1, n, mk_exec(2'd0, 1'b1, wasm_pkg::push_mem_const,
                    wasm_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b0), 1'b1, v, 1'b0);
        end
        add_row(64'hff, 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_I32_ADD), 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b1);
        apply_rows();
        finish_test("code opcodes", errs0);

        errs0 = errors;
        do_reset();
        add_header();
        add_code_open(8'd3);
        wb.push_back(`WASM_OP_I32_CONST);
        n = put_leb(32'd77);
        add_row(take_window(), 1'b1, n, mk_exec(2'd0, 1'b1, wasm_pkg::push_mem_const,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b0), 1'b1, 32'd77, 1'b0);
        add_row(64'(`WASM_OP_END), 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        apply_rows();
        // end opcode that also reads as section 11 with length 5
        consumed = 0;
        done     = 1'b0;
        while (!done && consumed < 16) begin
            @(posedge clk);
            #1;
            instr     = {48'h0, 8'h05, `WASM_OP_END};
            instr_vld = 1'b1;
            #2;
            if (shift_minus_one != 32'd0) begin
                done = 1'b1;
            end else begin
                consumed++;
            end
        end
        if (!done) begin
            $display("code section did not return to a section header within 16 windows");
            errors++;
        end else begin
            if (consumed != 2) begin
                $display("ERR t=%0t end_count exp=2 got=%0d", $time, consumed);
                errors++;
            end
            if (shift_minus_one != 32'd1) begin
                $display("ERR t=%0t shift_minus_one exp=1 got=%0d", $time, shift_minus_one);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        instr_vld = 1'b0;
        finish_test("code section end", errs0);

        errs0 = errors;
        do_reset();
        add_row(`WASM_MAGIC_VERSION, 1'b0, 32'd7, '0, 1'b0, 32'd0, 1'b0);
        add_header();
        add_code_open(8'd1);
        add_row(64'(`WASM_OP_I32_ADD), 1'b0, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_I32_ADD), 1'b1, 32'd0, mk_exec(2'd2, 1'b1, wasm_pkg::push_alu,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_END), 1'b0, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        wb.push_back(`WASM_OP_LOCAL_GET);
        n = put_leb(32'd5);
        add_row(take_window(), 1'b1, n, mk_exec(2'd0, 1'b1, wasm_pkg::push_local,
                wasm_pkg::alu_add, 1'b0, 1'b0, 1'b1, 1'b0), 1'b0, 32'd0, 1'b0);
        add_row(64'(`WASM_OP_END), 1'b1, 32'd0, '0, 1'b0, 32'd0, 1'b0);
        add_row(64'h0300, 1'b1, 32'd1, '0, 1'b0, 32'd0, 1'b0);
        apply_rows();
        finish_test("valid gating", errs0);

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // good magic after a bad one, error already set
    function automatic void add_header_err();
        add_row(`WASM_MAGIC_VERSION, 1'b1, 32'd7, '0, 1'b0, 32'd0, 1'b1);
    endfunction

endmodule

//--- flist.f
+incdir+logic
logic/wasm_pkg.sv
logic/leb128_decoder.sv
logic/section_parser.sv
logic/opcode_decoder.sv
logic/wasm_ctrl_unit.sv
test/wasm_ctrl_checker.sv
test/wasm_ctrl_tb.sv

//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert
TOP     = wasm_ctrl_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST)) logic/wasm_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
